/* include/rename_cfg.svh */
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// ==========================================================================
// Sizing of the rename and backout block
// ==========================================================================

// Number of reorder buffer entries
// Must stay a power of two so index arithmetic wraps for free
`define RENAME_ROB_ENTRIES 16

// Entries per instruction group
// Groups start on multiples of this value and it divides the ROB size
`define RENAME_GROUP_SIZE 4

// Architectural register count seen by the instruction set
`define RENAME_AREGS 32

// Physical register count in the register file behind the RAT
`define RENAME_PREGS 64

`endif

/* src/rename_pkg.sv */
`default_nettype none

// Widths are derived from the sizing header so the types follow any resize
`include "rename_cfg.svh"

package rename_pkg;

	// ==========================================================================
	// Index and register number types
	// ==========================================================================

	// Position of an entry inside the reorder buffer
	typedef logic [$clog2(`RENAME_ROB_ENTRIES)-1:0] rob_ndx_t;

	// Architectural register number as encoded in an instruction
	typedef logic [$clog2(`RENAME_AREGS)-1:0] aregno_t;

	// Physical register number held in the RAT and the ROB
	typedef logic [$clog2(`RENAME_PREGS)-1:0] pregno_t;

	// States of the mispredict backout walk
	// The backward pass restores old mappings of the younger entries,
	// the forward pass replays new mappings up to the branch
	typedef enum logic [1:0] {
		bo_idle,
		bo_backward,
		bo_forward
	} backout_state_t;

endpackage

`default_nettype wire

/* src/rob_store.sv */
`default_nettype none

`include "rename_cfg.svh"

// Reorder buffer storage for the rename fields.
// Only the fields needed by the backout walk are kept here: the
// destination register, the mapping it had before rename and the
// mapping it was given.
module rob_store (
	input  logic                clk,
	input  logic                rst,

	// Rename port
	input  logic                rename_valid,
	input  logic                stall,
	input  rename_pkg::aregno_t rename_areg,
	input  rename_pkg::pregno_t rename_preg,
	input  rename_pkg::pregno_t rename_nreg,

	// Walk read port used by the backout machine
	input  rename_pkg::rob_ndx_t walk_ndx,
	output rename_pkg::aregno_t  walk_areg,
	output rename_pkg::pregno_t  walk_preg,
	output rename_pkg::pregno_t  walk_nreg,

	// Tail truncation after a mispredict
	input  logic                 trunc,
	input  rename_pkg::rob_ndx_t trunc_tail,
	output rename_pkg::rob_ndx_t tail
);

	// ==========================================================================
	// Entry storage
	// ==========================================================================

	// One array per field, indexed by ROB position
	rename_pkg::aregno_t areg_mem [`RENAME_ROB_ENTRIES];
	rename_pkg::pregno_t preg_mem [`RENAME_ROB_ENTRIES];
	rename_pkg::pregno_t nreg_mem [`RENAME_ROB_ENTRIES];

	// A rename is taken only while the backout machine is not holding the front end
	logic rename_accept;

	assign rename_accept = rename_valid && !stall;

	// The entry at tail receives the destination, the previous mapping
	// read from the RAT this cycle, and the freshly allocated register
	always_ff @(posedge clk) begin
		if (rename_accept) begin
			areg_mem[tail] <= rename_areg;
			preg_mem[tail] <= rename_preg;
			nreg_mem[tail] <= rename_nreg;
		end
	end

	// ==========================================================================
	// Tail pointer
	// ==========================================================================

	// Truncation wins over an append. Both never coincide because stall
	// is still high in the cycle trunc is pulsed
	always_ff @(posedge clk) begin
		if (rst) begin
			tail <= '0;
		end else if (trunc) begin
			tail <= trunc_tail;
		end else if (rename_accept) begin
			// Index width matches the power-of-two size so this wraps around
			tail <= tail + rename_pkg::rob_ndx_t'(1);
		end
	end

	// ==========================================================================
	// Walk read port
	// ==========================================================================

	// Plain combinational read
	// The backout machine registers whatever it takes from here
	assign walk_areg = areg_mem[walk_ndx];
	assign walk_preg = preg_mem[walk_ndx];
	assign walk_nreg = nreg_mem[walk_ndx];

endmodule

`default_nettype wire

/* src/rename_map_table.sv */
`default_nettype none

`include "rename_cfg.svh"

// Register alias table.
// Holds the current physical register for each architectural register.
// Written by rename and by the backout repair, read by rename (to capture
// the old mapping) and by the source lookup port.
module rename_map_table (
	input  logic                clk,
	input  logic                rst,

	// Rename port
	input  logic                rename_valid,
	input  logic                stall,
	input  rename_pkg::aregno_t rename_areg,
	input  rename_pkg::pregno_t rename_nreg,
	output rename_pkg::pregno_t rename_preg,

	// Repair writes from the backout machine
	input  logic                bo_wr,
	input  rename_pkg::aregno_t bo_areg,
	input  rename_pkg::pregno_t bo_preg,

	// Source operand lookup
	input  rename_pkg::aregno_t src_areg,
	output rename_pkg::pregno_t src_preg
);

	// ==========================================================================
	// Map storage
	// ==========================================================================

	rename_pkg::pregno_t map_mem [`RENAME_AREGS];

	// Reset gives an identity map so that every register starts out
	// living in the physical register of the same number.
	// A repair write takes priority over rename; with stall obeyed
	// by the rename source the two are never seen together
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `RENAME_AREGS; i++) begin
				map_mem[i] <= rename_pkg::pregno_t'(i);
			end
		end else if (bo_wr) begin
			map_mem[bo_areg] <= bo_preg;
		end else if (rename_valid && !stall) begin
			map_mem[rename_areg] <= rename_nreg;
		end
	end

	// ==========================================================================
	// Read ports
	// ==========================================================================

	// Mapping before this rename. It goes into the ROB entry as the old
	// register so a backout can put it back
	assign rename_preg = map_mem[rename_areg];

	// Lookup for source operands
	assign src_preg = map_mem[src_areg];

endmodule

`default_nettype wire

/* src/rat_backout_machine.sv */
`default_nettype none

`include "rename_cfg.svh"

// Mispredict backout machine.
// On a mispredict it repairs the RAT for the branch's own group only:
// first walking down from the youngest occupied group entry to the entry
// just after the branch, writing back each old mapping, then walking up
// from the first entry of the group to the branch itself, writing each
// new mapping again. At the end the ROB tail is cut back to just after
// the branch.
module rat_backout_machine (
	input  logic                 clk,
	input  logic                 rst,

	// Mispredict request
	input  logic                 backout,
	input  rename_pkg::rob_ndx_t fcu_id,

	// ROB side
	input  rename_pkg::rob_ndx_t tail,
	output rename_pkg::rob_ndx_t walk_ndx,
	input  rename_pkg::aregno_t  walk_areg,
	input  rename_pkg::pregno_t  walk_preg,
	input  rename_pkg::pregno_t  walk_nreg,

	// RAT repair writes
	output logic                 bo_wr,
	output rename_pkg::aregno_t  bo_areg,
	output rename_pkg::pregno_t  bo_preg,

	// Tail truncation and front end hold
	output logic                 trunc,
	output rename_pkg::rob_ndx_t trunc_tail,
	output logic                 stall
);

	// Low index bits that give the position inside a group
	localparam rename_pkg::rob_ndx_t GRP_MASK =
		rename_pkg::rob_ndx_t'(`RENAME_GROUP_SIZE - 1);

	rename_pkg::backout_state_t state;

	// Branch index and first entry of its group, held for the whole walk
	rename_pkg::rob_ndx_t br_ndx;
	rename_pkg::rob_ndx_t grp_start;
	rename_pkg::rob_ndx_t br_next;

	// Start point computed from the incoming request
	rename_pkg::rob_ndx_t younger_tail;
	rename_pkg::rob_ndx_t younger_grp;
	rename_pkg::rob_ndx_t younger_cnt;
	rename_pkg::rob_ndx_t grp_first;

	// ==========================================================================
	// Walk bounds
	// ==========================================================================

	always_comb begin
		// Occupied entries younger than the branch, up to tail minus one
		younger_tail = tail - rename_pkg::rob_ndx_t'(1) - fcu_id;
		// Entries left in the branch's group after the branch
		younger_grp = GRP_MASK - (fcu_id & GRP_MASK);
		// Only entries that are both occupied and in the group need undoing
		younger_cnt = (younger_tail < younger_grp) ? younger_tail : younger_grp;
		grp_first = fcu_id & ~GRP_MASK;
	end

	// Entry just after the branch: last visit of the backward pass and
	// also the new tail once the walk is over
	assign br_next = br_ndx + rename_pkg::rob_ndx_t'(1);
	assign trunc_tail = br_next;

	// ==========================================================================
	// State machine
	// ==========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= rename_pkg::bo_idle;
			walk_ndx <= '0;
			trunc <= 1'b0;
		end else begin
			trunc <= 1'b0;
			case (state)
				rename_pkg::bo_idle: begin
					if (backout) begin
						if (younger_cnt != '0) begin
							// Start with the youngest occupied entry of the group
							state <= rename_pkg::bo_backward;
							walk_ndx <= fcu_id + younger_cnt;
						end else begin
							// Nothing younger to undo, go straight to the replay
							state <= rename_pkg::bo_forward;
							walk_ndx <= grp_first;
						end
					end
				end
				rename_pkg::bo_backward: begin
					if (walk_ndx == br_next) begin
						state <= rename_pkg::bo_forward;
						walk_ndx <= grp_start;
					end else begin
						walk_ndx <= walk_ndx - rename_pkg::rob_ndx_t'(1);
					end
				end
				rename_pkg::bo_forward: begin
					// The branch entry is the last one replayed
					if (walk_ndx == br_ndx) begin
						state <= rename_pkg::bo_idle;
						trunc <= 1'b1;
					end else begin
						walk_ndx <= walk_ndx + rename_pkg::rob_ndx_t'(1);
					end
				end
				default: begin
					state <= rename_pkg::bo_idle;
				end
			endcase
		end
	end

	// Branch position and group start are captured with the request
	always_ff @(posedge clk) begin
		if (state == rename_pkg::bo_idle && backout) begin
			br_ndx <= fcu_id;
			grp_start <= grp_first;
		end
	end

	// ==========================================================================
	// Repair writes
	// ==========================================================================

	// One write per visited entry, one cycle after the visit
	always_ff @(posedge clk) begin
		if (rst) begin
			bo_wr <= 1'b0;
		end else begin
			bo_wr <= (state != rename_pkg::bo_idle);
		end
	end

	// Backward pass restores the old mapping, forward pass the new one
	always_ff @(posedge clk) begin
		if (state != rename_pkg::bo_idle) begin
			bo_areg <= walk_areg;
			bo_preg <= (state == rename_pkg::bo_backward) ? walk_preg : walk_nreg;
		end
	end

	// Hold rename from the request until the final repair write is done
	assign stall = backout || (state != rename_pkg::bo_idle) || bo_wr;

endmodule

`default_nettype wire

/* src/rename_backout_top.sv */
`default_nettype none

// Rename and mispredict backout block.
// Ties the ROB storage, the RAT and the backout machine together.
module rename_backout_top (
	input  logic                 clk,
	input  logic                 rst,

	// Rename port
	input  logic                 rename_valid,
	input  rename_pkg::aregno_t  rename_areg,
	input  rename_pkg::pregno_t  rename_nreg,

	// Mispredict port
	input  logic                 backout,
	input  rename_pkg::rob_ndx_t fcu_id,

	// Source lookup
	input  rename_pkg::aregno_t  src_areg,
	output rename_pkg::pregno_t  src_preg,

	// Front end hold during a backout
	output logic                 stall
);

	// ==========================================================================
	// Internal nets
	// ==========================================================================

	// Old mapping of the renamed register, read from the RAT
	rename_pkg::pregno_t  rename_preg;

	// Walk interface between the machine and the ROB
	rename_pkg::rob_ndx_t walk_ndx;
	rename_pkg::aregno_t  walk_areg;
	rename_pkg::pregno_t  walk_preg;
	rename_pkg::pregno_t  walk_nreg;
	rename_pkg::rob_ndx_t tail;
	logic                 trunc;
	rename_pkg::rob_ndx_t trunc_tail;

	// Repair writes into the RAT
	logic                 bo_wr;
	rename_pkg::aregno_t  bo_areg;
	rename_pkg::pregno_t  bo_preg;

	rob_store u_rob (
		.clk          (clk),
		.rst          (rst),
		.rename_valid (rename_valid),
		.stall        (stall),
		.rename_areg  (rename_areg),
		.rename_preg  (rename_preg),
		.rename_nreg  (rename_nreg),
		.walk_ndx     (walk_ndx),
		.walk_areg    (walk_areg),
		.walk_preg    (walk_preg),
		.walk_nreg    (walk_nreg),
		.trunc        (trunc),
		.trunc_tail   (trunc_tail),
		.tail         (tail)
	);

	rename_map_table u_rat (
		.clk          (clk),
		.rst          (rst),
		.rename_valid (rename_valid),
		.stall        (stall),
		.rename_areg  (rename_areg),
		.rename_nreg  (rename_nreg),
		.rename_preg  (rename_preg),
		.bo_wr        (bo_wr),
		.bo_areg      (bo_areg),
		.bo_preg      (bo_preg),
		.src_areg     (src_areg),
		.src_preg     (src_preg)
	);

	rat_backout_machine u_backout (
		.clk        (clk),
		.rst        (rst),
		.backout    (backout),
		.fcu_id     (fcu_id),
		.tail       (tail),
		.walk_ndx   (walk_ndx),
		.walk_areg  (walk_areg),
		.walk_preg  (walk_preg),
		.walk_nreg  (walk_nreg),
		.bo_wr      (bo_wr),
		.bo_areg    (bo_areg),
		.bo_preg    (bo_preg),
		.trunc      (trunc),
		.trunc_tail (trunc_tail),
		.stall      (stall)
	);

endmodule

`default_nettype wire

/* verif/tb_rename_backout.sv */
`default_nettype none

`include "rename_cfg.svh"

module tb_rename_backout;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ROB = `RENAME_ROB_ENTRIES;
	localparam int GS = `RENAME_GROUP_SIZE;
	localparam int AREGS = `RENAME_AREGS;
	localparam int STALL_LIMIT = 64;
	localparam int SWEEP_LIMIT = 4 * AREGS;

	logic                 clk;
	logic                 rst;
	logic                 rename_valid;
	rename_pkg::aregno_t  rename_areg;
	rename_pkg::pregno_t  rename_nreg;
	logic                 backout;
	rename_pkg::rob_ndx_t fcu_id;
	rename_pkg::aregno_t  src_areg;
	rename_pkg::pregno_t  src_preg;
	logic                 stall;

	// Model ROB fields and model RAT, kept in step with every rename
	rename_pkg::aregno_t rob_areg [ROB];
	rename_pkg::pregno_t rob_old [ROB];
	rename_pkg::pregno_t rob_new [ROB];
	rename_pkg::pregno_t model_rat [AREGS];
	// Copy of the model map taken right after a branch renamed
	rename_pkg::pregno_t snap [AREGS];
	int model_tail;
	// Entries written since reset, less those cut off by truncation
	int live;

	int seed = 32'h72a35a1e;
	int main_errors = 0;
	int sweep_errors = 0;
	int sweep_req = 0;
	int sweep_ack = 0;
	int tests_run = 0;
	int tests_failed = 0;
	bit aborted = 1'b0;

	rename_backout_top u_dut (
		.clk          (clk),
		.rst          (rst),
		.rename_valid (rename_valid),
		.rename_areg  (rename_areg),
		.rename_nreg  (rename_nreg),
		.backout      (backout),
		.fcu_id       (fcu_id),
		.src_areg     (src_areg),
		.src_preg     (src_preg),
		.stall        (stall)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ==========================================================================
	// Reference model
	// ==========================================================================

	// Repairs the model map for the branch at br: old mappings of the occupied
	// younger group entries from the youngest down, then new mappings from the
	// group start up to the branch. Returns the number of RAT writes
	function automatic int apply_backout(input int br);
		int pos;
		int tail_left;
		int grp_left;
		int cnt;
		int idx;
		int k;
		pos = br % GS;
		tail_left = ((model_tail - 1 - br) % ROB + ROB) % ROB;
		grp_left = GS - 1 - pos;
		cnt = (tail_left < grp_left) ? tail_left : grp_left;
		for (k = cnt; k >= 1; k--) begin
			idx = (br + k) % ROB;
			model_rat[rob_areg[idx]] = rob_old[idx];
		end
		for (idx = br - pos; idx <= br; idx++) begin
			model_rat[rob_areg[idx]] = rob_new[idx];
		end
		model_tail = (br + 1) % ROB;
		return cnt + pos + 1;
	endfunction

	function automatic rename_pkg::aregno_t rand_areg(input int mask);
		return rename_pkg::aregno_t'($random(seed) & mask);
	endfunction

	function automatic rename_pkg::pregno_t rand_preg();
		return rename_pkg::pregno_t'($random(seed));
	endfunction

	function automatic int error_total();
		return main_errors + sweep_errors;
	endfunction

	// ==========================================================================
	// Stimulus tasks
	// ==========================================================================

	task automatic rename_one(input rename_pkg::aregno_t a, input rename_pkg::pregno_t n);
		@(posedge clk);
		rename_valid <= 1'b1;
		rename_areg <= a;
		rename_nreg <= n;
		// The entry keeps the mapping the RAT held just before this rename
		rob_areg[model_tail] = a;
		rob_old[model_tail] = model_rat[a];
		rob_new[model_tail] = n;
		model_rat[a] = n;
		model_tail = (model_tail + 1) % ROB;
		if (live < ROB) begin
			live++;
		end
	endtask

	task automatic rename_stop();
		@(posedge clk);
		rename_valid <= 1'b0;
	endtask

	task automatic wait_stall_low(output int high_cycles);
		int n;
		n = 0;
		@(negedge clk);
		while (stall && n < STALL_LIMIT) begin
			n++;
			@(negedge clk);
		end
		if (stall) begin
			$display("Timeout: stall stayed high for %0d cycles after a backout", STALL_LIMIT);
			aborted = 1'b1;
		end
		high_cycles = n;
	endtask

	// One-cycle backout pulse, then the end of the walk shows as stall falling
	task automatic mispredict(input int br);
		int writes;
		int high_cycles;
		if (aborted) return;
		live = live - ((model_tail - 1 - br) % ROB + ROB) % ROB;
		writes = apply_backout(br);
		@(posedge clk);
		rename_valid <= 1'b0;
		backout <= 1'b1;
		fcu_id <= rename_pkg::rob_ndx_t'(br);
		// The hold toward the rename source starts in the pulse cycle itself
		@(negedge clk);
		if (stall !== 1'b1) begin
			$display("FAIL %0t: stall is %b in the backout cycle of entry %0d, expected 1",
				$time, stall, br);
			main_errors++;
		end
		@(posedge clk);
		backout <= 1'b0;
		wait_stall_low(high_cycles);
		// Stall covers the pulse cycle plus one cycle per write plus one
		if (!aborted && high_cycles + 1 != writes + 2) begin
			$display("FAIL %0t: backout on entry %0d held stall %0d cycles, expected %0d",
				$time, br, high_cycles + 1, writes + 2);
			main_errors++;
		end
	endtask

	task automatic check_map();
		int n;
		if (aborted) return;
		sweep_req++;
		n = 0;
		while (sweep_ack != sweep_req && n < SWEEP_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (sweep_ack != sweep_req) begin
			$display("Timeout: the map sweep did not finish within %0d cycles", SWEEP_LIMIT);
			aborted = 1'b1;
		end
	endtask

	task automatic match_snapshot(input string what);
		int i;
		for (i = 0; i < AREGS; i++) begin
			if (model_rat[i] !== snap[i]) begin
				$display("FAIL %0t: %s, areg %0d is %0d in the repaired map, expected %0d",
					$time, what, i, model_rat[i], snap[i]);
				main_errors++;
			end
		end
	endtask

	task automatic end_test(input string name, input int start);
		int errs;
		errs = error_total() - start;
		tests_run++;
		if (errs == 0 && !aborted) begin
			$display("Test %0d, %s: passed", tests_run, name);
		end else begin
			tests_failed++;
			$display("Test %0d, %s: failed with %0d errors", tests_run, name, errs);
		end
	endtask

	// ==========================================================================
	// Compare process
	// ==========================================================================

	// Sweeps every architectural register through the lookup port on request
	initial begin : map_compare
		int i;
		src_areg <= '0;
		forever begin
			@(posedge clk);
			if (sweep_ack != sweep_req) begin
				for (i = 0; i < AREGS; i++) begin
					src_areg <= rename_pkg::aregno_t'(i);
					@(negedge clk);
					if (src_preg !== model_rat[i]) begin
						$display("FAIL %0t: areg %0d maps to preg %0d, expected %0d",
							$time, i, src_preg, model_rat[i]);
						sweep_errors++;
					end
					if (i < AREGS - 1) begin
						@(posedge clk);
					end
				end
				sweep_ack++;
			end
		end
	end

	// ==========================================================================
	// Tests
	// ==========================================================================

	task automatic identity_after_reset();
		int start;
		start = error_total();
		@(negedge clk);
		if (stall !== 1'b0) begin
			$display("FAIL %0t: stall is %b after reset, expected 0", $time, stall);
			main_errors++;
		end
		check_map();
		end_test("identity map after reset", start);
	endtask

	task automatic random_rename_run();
		int start;
		int i;
		start = error_total();
		for (i = 0; i < 12; i++) begin
			rename_one(rand_areg(AREGS - 1), rand_preg());
		end
		rename_stop();
		check_map();
		end_test("random rename sequence", start);
	endtask

	// Fills the group after the twelve earlier renames; the two youngest
	// entries write the same register
	task automatic mid_group_backout();
		int start;
		int br;
		start = error_total();
		rename_one(rename_pkg::aregno_t'(3), rand_preg());
		br = model_tail;
		rename_one(rename_pkg::aregno_t'(7), rand_preg());
		snap = model_rat;
		rename_one(rename_pkg::aregno_t'(9), rand_preg());
		rename_one(rename_pkg::aregno_t'(9), rand_preg());
		mispredict(br);
		match_snapshot("branch in mid group");
		check_map();
		end_test("mispredict in mid group", start);
	endtask

	task automatic youngest_entry_backout();
		int start;
		int br;
		start = error_total();
		br = model_tail;
		rename_one(rename_pkg::aregno_t'(11), rand_preg());
		snap = model_rat;
		mispredict(br);
		match_snapshot("youngest branch");
		check_map();
		end_test("mispredict on youngest entry", start);
	endtask

	// A first backout cuts the tail, the next renames must refill from there
	task automatic refill_after_truncation();
		int start;
		int br;
		start = error_total();
		rename_one(rename_pkg::aregno_t'(5), rand_preg());
		rename_one(rename_pkg::aregno_t'(6), rand_preg());
		rename_one(rename_pkg::aregno_t'(8), rand_preg());
		mispredict((model_tail + ROB - 3) % ROB);
		rename_one(rename_pkg::aregno_t'(20), rand_preg());
		br = model_tail;
		rename_one(rename_pkg::aregno_t'(21), rand_preg());
		snap = model_rat;
		rename_one(rename_pkg::aregno_t'(20), rand_preg());
		mispredict(br);
		match_snapshot("branch after truncation");
		check_map();
		end_test("renames after truncation", start);
	endtask

	task automatic bursts_with_backouts();
		int start;
		int iter;
		int burst;
		int j;
		int k;
		start = error_total();
		for (iter = 0; iter < 40 && !aborted; iter++) begin
			burst = ($random(seed) & 32'h7fffffff) % 6 + 1;
			for (j = 0; j < burst; j++) begin
				// A small register set forces repeated destinations
				rename_one(rand_areg(7), rand_preg());
			end
			k = ($random(seed) & 32'h7fffffff) % ((live < 6) ? live : 6);
			mispredict((model_tail - 1 - k + ROB) % ROB);
			check_map();
		end
		end_test("random bursts and mispredicts", start);
	endtask

	initial begin : main_sequence
		int i;
		rst <= 1'b1;
		rename_valid <= 1'b0;
		rename_areg <= '0;
		rename_nreg <= '0;
		backout <= 1'b0;
		fcu_id <= '0;
		for (i = 0; i < AREGS; i++) begin
			model_rat[i] = rename_pkg::pregno_t'(i);
		end
		model_tail = 0;
		live = 0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		if (!aborted) identity_after_reset();
		if (!aborted) random_rename_run();
		if (!aborted) mid_group_backout();
		if (!aborted) youngest_entry_backout();
		if (!aborted) refill_after_truncation();
		if (!aborted) bursts_with_backouts();
		$display("Tests run %0d, failed %0d, mismatches %0d",
			tests_run, tests_failed, error_total());
		if (aborted || error_total() != 0) begin
			$display("TEST FAILED");
		end else begin
			$display("TEST OK");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
src/rename_pkg.sv
src/rob_store.sv
src/rename_map_table.sv
src/rat_backout_machine.sv
src/rename_backout_top.sv
verif/tb_rename_backout.sv

/* Makefile */
# Verilator build and run for the rename and backout testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_rename_backout
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_TEXT ?= TEST OK

SOURCES := $(wildcard include/*.svh src/*.sv verif/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
